//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --assert -Wno-fatal
TOP       = txLtssmTb
FILELIST  = txLtssm.f
SRCS      = $(shell grep -v '^+' $(FILELIST)) include/ltssm_macros.svh

# isUpstream value per build
ROLE_dsp = 0
ROLE_usp = 1

.PHONY: all run run_dsp run_usp clean

all: run

run: run_dsp run_usp

obj_%/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -GisUpstream=$(ROLE_$*) --top-module $(TOP) \
		--Mdir obj_$* -f $(FILELIST)

run_dsp run_usp: run_%: obj_%/V$(TOP)
	./$< > $*.log 2>&1; cat $*.log; grep -qx 'Test OK' $*.log

clean:
	rm -rf obj_dsp obj_usp dsp.log usp.log

//--- include/ltssm_macros.svh
`ifndef LTSSM_MACROS_SVH
`define LTSSM_MACROS_SVH

// Link geometry
`define LTSSM_LANES 16
`define LTSSM_LANE_COUNT_W 5
`define LTSSM_STATE_W 5
`define LTSSM_LINK_NUM_W 8
`define LTSSM_OS_COUNT_W 16

// Detect interval in Pclk cycles, scaled down from 12 ms
`define LTSSM_DETECT_CYCLES 12

// Ordered-set counts that close a state
`define LTSSM_POLL_ACTIVE_OS 1024
`define LTSSM_POLL_CFG_OS 20
`define LTSSM_CPL_OS_DSP 25
`define LTSSM_CPL_OS_USP 18
`define LTSSM_IDLE_AFTER_SEND16 7

// Link number a downstream port offers in LinkWidth.Start
`define LTSSM_DSP_LINK_NUM 1

`endif

//--- rtl/laneDetect.sv
`default_nettype none
`include "ltssm_macros.svh"

module laneDetect (
	input  wire                                Pclk,
	input  wire                                rstN,
	input  wire  [`LTSSM_LANES-1:0]            DetectStatus,
	input  wire                                captureLanes,
	output logic                               allDetected,
	output logic                               noneDetected,
	output logic [`LTSSM_LANES-1:0]            DetectLanes,
	output logic [`LTSSM_LANE_COUNT_W-1:0]     NumberDetectLanes,
	output logic                               WriteDetectLanesFlag
);

	// Receiver detect result as PIPE reports it now
	assign allDetected = &DetectStatus;
	assign noneDetected = ~|DetectStatus;

	always_ff @(posedge Pclk) begin
		if (!rstN) begin
			DetectLanes <= '0;
			WriteDetectLanesFlag <= 1'b0;
		end else begin
			if (captureLanes) begin
				DetectLanes <= DetectStatus;
			end
			WriteDetectLanesFlag <= captureLanes; // Lanes are valid by now
		end
	end

	// Highest detected lane decides the width
	always_comb begin
		NumberDetectLanes = '0;
		for (int i = 0; i < `LTSSM_LANES; i++) begin
			if (DetectLanes[i]) begin
				NumberDetectLanes = `LTSSM_LANE_COUNT_W'(i + 1);
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/ltssmPkg.sv
`default_nettype none
`include "ltssm_macros.svh"

package ltssmPkg;

	// Same codes as the main LTSSM uses on SetTXState
	typedef enum logic [`LTSSM_STATE_W-1:0] {
		DetectQuiet           = 5'd0,
		DetectActive          = 5'd1,
		PollingActive         = 5'd2,
		PollingConfig         = 5'd3,
		ConfigLinkWidthStart  = 5'd4,
		ConfigLinkWidthAccept = 5'd5,
		ConfigLaneNumWait     = 5'd6,
		ConfigLaneNumActive   = 5'd7,
		ConfigComplete        = 5'd8,
		ConfigIdle            = 5'd9,
		L0                    = 5'd10,
		Idle                  = 5'd31 // Parked here after reset
	} ltssmStateE;

	// Ordered-set select toward the generator
	typedef enum logic [2:0] {
		OsTs1  = 3'd0,
		OsTs2  = 3'd1,
		OsIdle = 3'd4
	} osTypeE;

	typedef enum logic [2:0] {
		tNone = 3'b000,
		t12ms = 3'b001
	} timerCodeE;

endpackage

`default_nettype wire

//--- rtl/ltssmTimer.sv
`default_nettype none
`include "ltssm_macros.svh"

module ltssmTimer (
	input  wire                      Pclk,
	input  wire                      rstN,
	input  wire                      start,
	input  wire ltssmPkg::timerCodeE code,
	output logic                     timeOut
);
	localparam int cntW = $clog2(`LTSSM_DETECT_CYCLES + 1);

	logic [cntW-1:0] count;
	logic [cntW-1:0] loadVal;
	logic armed;

	always_comb begin
		case (code)
			ltssmPkg::t12ms: loadVal = cntW'(`LTSSM_DETECT_CYCLES - 1); // Zero on cycle N after start
			default: loadVal = '0;
		endcase
	end

	always_ff @(posedge Pclk) begin
		if (!rstN) begin
			armed <= 1'b0;
			count <= '0;
		end else if (start) begin
			armed <= 1'b1;
			count <= loadVal;
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	assign timeOut = armed && (count == '0); // Stays up until the next start

	// Main LTSSM must not hop between Detect states on consecutive cycles
	startSpaced: assert property (@(posedge Pclk) disable iff (!rstN) start |=> !start)
		else $error("timer started on two consecutive cycles");

endmodule

`default_nettype wire

//--- rtl/osRequest.sv
`default_nettype none
`include "ltssm_macros.svh"

module osRequest #(
	parameter bit isUpstream = 1'b0
) (
	input  wire                          Pclk,
	input  wire                          rstN,
	input  wire ltssmPkg::ltssmStateE    state,
	input  wire                          OSGeneratorBusy,
	input  wire  [`LTSSM_LINK_NUM_W-1:0] ReadLinkNum,
	output logic [2:0]                   OSType,
	output logic [`LTSSM_LINK_NUM_W-1:0] LinkNumber,
	output logic [1:0]                   LaneNumber,
	output logic [2:0]                   Rate,
	output logic                         Loopback,
	output logic                         OSGeneratorStart,
	output logic [`LTSSM_LINK_NUM_W-1:0] WriteLinkNum,
	output logic                         WriteLinkNumFlag,
	output logic                         HoldFIFOData,
	output logic                         MuxSel,
	output logic [`LTSSM_LANES-1:0]      DetectReq,
	output logic [`LTSSM_LANES-1:0]      ElecIdleReq,
	output logic                         turnOffScrambler
);
	localparam logic [2:0] rateGen1 = 3'd1;
	localparam logic [2:0] upIdleBeforeScr = 3'd4; // IDLEs an upstream port sends scrambled-off

	ltssmPkg::osTypeE osTypeNext;
	logic [`LTSSM_LINK_NUM_W-1:0] linkNext;
	logic [1:0] laneNext;
	logic needOs, proposeLink, startNow;
	logic scrNext, scrDly;
	logic [2:0] idleCnt;

	always_comb begin
		needOs = 1'b1;
		osTypeNext = ltssmPkg::OsTs1;
		linkNext = ReadLinkNum;
		laneNext = 2'd1;
		proposeLink = 1'b0;
		case (state)
			ltssmPkg::PollingActive: begin
				linkNext = '0;
				laneNext = '0;
			end
			ltssmPkg::PollingConfig: begin
				osTypeNext = ltssmPkg::OsTs2;
				linkNext = '0;
				laneNext = '0;
			end
			ltssmPkg::ConfigLinkWidthStart: begin
				laneNext = '0;
				linkNext = isUpstream ? '0 : `LTSSM_LINK_NUM_W'(`LTSSM_DSP_LINK_NUM); // Pad if upstream
				proposeLink = !isUpstream;
			end
			ltssmPkg::ConfigLinkWidthAccept: laneNext = isUpstream ? 2'd0 : 2'd1;
			ltssmPkg::ConfigLaneNumWait, ltssmPkg::ConfigLaneNumActive: ;
			ltssmPkg::ConfigComplete: osTypeNext = ltssmPkg::OsTs2;
			ltssmPkg::ConfigIdle: osTypeNext = ltssmPkg::OsIdle;
			default: needOs = 1'b0; // Detect, L0 and Idle send no training sets
		endcase
	end

	// Generator raises Busy the cycle after a start, so never start twice in a row
	assign startNow = needOs && !OSGeneratorBusy && !OSGeneratorStart;

	always_comb begin
		case (state)
			ltssmPkg::ConfigIdle: scrNext = isUpstream ? (idleCnt < upIdleBeforeScr) : 1'b0;
			ltssmPkg::L0: scrNext = 1'b0;
			default: scrNext = 1'b1;
		endcase
	end

	always_ff @(posedge Pclk) begin
		if (!rstN) begin
			OSGeneratorStart <= 1'b0;
			WriteLinkNumFlag <= 1'b0;
			HoldFIFOData <= 1'b1;
			MuxSel <= 1'b0;
			DetectReq <= '0;
			ElecIdleReq <= '0;
			idleCnt <= '0;
			scrDly <= 1'b1;
			turnOffScrambler <= 1'b1;
		end else begin
			OSGeneratorStart <= startNow;
			WriteLinkNumFlag <= startNow && proposeLink;
			HoldFIFOData <= state != ltssmPkg::L0; // FIFO released only in L0
			MuxSel <= state == ltssmPkg::L0;
			DetectReq <= {`LTSSM_LANES{state == ltssmPkg::DetectActive}};
			ElecIdleReq <= {`LTSSM_LANES{state == ltssmPkg::DetectQuiet}};
			if (state != ltssmPkg::ConfigIdle) begin
				idleCnt <= '0;
			end else if (startNow && idleCnt != upIdleBeforeScr) begin
				idleCnt <= idleCnt + 1'b1;
			end
			scrDly <= scrNext;
			turnOffScrambler <= scrDly;
		end
	end

	// Fields change only with a start and hold while the generator is busy
	always_ff @(posedge Pclk) begin
		if (startNow) begin
			OSType <= osTypeNext;
			LinkNumber <= linkNext;
			LaneNumber <= laneNext;
			Rate <= rateGen1;
			Loopback <= 1'b0;
			WriteLinkNum <= linkNext;
		end
	end

	// Generator must still be idle when a start lands
	startWhenFree: assert property (@(posedge Pclk) disable iff (!rstN)
		OSGeneratorStart |-> !OSGeneratorBusy)
		else $error("ordered-set generator busy while a start is issued");

endmodule

`default_nettype wire

//--- rtl/txLtssm.sv
`default_nettype none
`include "ltssm_macros.svh"

module txLtssm #(
	parameter bit isUpstream = 1'b0 // 0 downstream, 1 upstream
) (
	input  wire                            Pclk,
	input  wire                            rstN,
	// Main LTSSM side
	input  wire  [`LTSSM_STATE_W-1:0]      SetTXState,
	output logic                           TXFinishFlag,
	output logic [`LTSSM_STATE_W-1:0]      TXExitTo,
	output logic [`LTSSM_LINK_NUM_W-1:0]   WriteLinkNum,
	output logic                           WriteLinkNumFlag,
	input  wire  [`LTSSM_LINK_NUM_W-1:0]   ReadLinkNum,
	output logic [`LTSSM_LANE_COUNT_W-1:0] NumberDetectLanes,
	output logic [`LTSSM_LANES-1:0]        DetectLanes,
	output logic                           WriteDetectLanesFlag,
	// Ordered-set generator
	output logic [2:0]                     OSType,
	output logic [1:0]                     LaneNumber,
	output logic [`LTSSM_LINK_NUM_W-1:0]   LinkNumber,
	output logic [2:0]                     Rate,
	output logic                           Loopback,
	output logic                           OSGeneratorStart,
	input  wire                            OSGeneratorBusy,
	input  wire                            OSGeneratorFinish,
	input  wire                            startSend16,
	output logic                           turnOffScrambler,
	// Data path and PIPE
	output logic                           HoldFIFOData,
	output logic                           MuxSel,
	output logic [`LTSSM_LANES-1:0]        DetectReq,
	output logic [`LTSSM_LANES-1:0]        ElecIdleReq,
	input  wire  [`LTSSM_LANES-1:0]        DetectStatus
);
	ltssmPkg::ltssmStateE state;
	ltssmPkg::timerCodeE timerCode;
	logic timerStart, timeOut;
	logic allDetected, noneDetected, captureLanes;

	ltssmTimer timer (
		.Pclk(Pclk), .rstN(rstN), .start(timerStart), .code(timerCode), .timeOut(timeOut)
	);

	laneDetect laneDet (
		.Pclk(Pclk), .rstN(rstN), .DetectStatus(DetectStatus), .captureLanes(captureLanes),
		.allDetected(allDetected), .noneDetected(noneDetected), .DetectLanes(DetectLanes),
		.NumberDetectLanes(NumberDetectLanes), .WriteDetectLanesFlag(WriteDetectLanesFlag)
	);

	txStateTrack #(.isUpstream(isUpstream)) stateTrack (
		.Pclk(Pclk), .rstN(rstN), .SetTXState(SetTXState),
		.OSGeneratorFinish(OSGeneratorFinish), .startSend16(startSend16),
		.timeOut(timeOut), .allDetected(allDetected), .noneDetected(noneDetected),
		.state(state), .timerStart(timerStart), .timerCode(timerCode),
		.captureLanes(captureLanes), .TXFinishFlag(TXFinishFlag), .TXExitTo(TXExitTo)
	);

	osRequest #(.isUpstream(isUpstream)) osReq (
		.Pclk(Pclk), .rstN(rstN), .state(state), .OSGeneratorBusy(OSGeneratorBusy),
		.ReadLinkNum(ReadLinkNum), .OSType(OSType), .LinkNumber(LinkNumber),
		.LaneNumber(LaneNumber), .Rate(Rate), .Loopback(Loopback),
		.OSGeneratorStart(OSGeneratorStart), .WriteLinkNum(WriteLinkNum),
		.WriteLinkNumFlag(WriteLinkNumFlag), .HoldFIFOData(HoldFIFOData), .MuxSel(MuxSel),
		.DetectReq(DetectReq), .ElecIdleReq(ElecIdleReq), .turnOffScrambler(turnOffScrambler)
	);

endmodule

`default_nettype wire

//--- rtl/txStateTrack.sv
`default_nettype none
`include "ltssm_macros.svh"

module txStateTrack #(
	parameter bit isUpstream = 1'b0
) (
	input  wire                        Pclk,
	input  wire                        rstN,
	input  wire  [`LTSSM_STATE_W-1:0]  SetTXState,
	input  wire                        OSGeneratorFinish,
	input  wire                        startSend16,
	input  wire                        timeOut,
	input  wire                        allDetected,
	input  wire                        noneDetected,
	output ltssmPkg::ltssmStateE       state,
	output logic                       timerStart,
	output ltssmPkg::timerCodeE        timerCode,
	output logic                       captureLanes,
	output logic                       TXFinishFlag,
	output logic [`LTSSM_STATE_W-1:0]  TXExitTo
);
	localparam int osW = `LTSSM_OS_COUNT_W;
	localparam logic [osW-1:0] pollActiveOs = `LTSSM_POLL_ACTIVE_OS;
	localparam logic [osW-1:0] pollCfgOs = `LTSSM_POLL_CFG_OS;
	localparam logic [osW-1:0] cplOs = isUpstream ? `LTSSM_CPL_OS_USP : `LTSSM_CPL_OS_DSP;
	localparam logic [osW-1:0] idleOs = `LTSSM_IDLE_AFTER_SEND16;

	ltssmPkg::ltssmStateE nextState;
	ltssmPkg::ltssmStateE prevState;
	ltssmPkg::ltssmStateE exitTo;
	logic [osW-1:0] osCount;
	logic [osW-1:0] markCount;
	logic stateChange, entered, timeOutQ;
	logic exitFound, exitGo;
	logic send16Q, send16Rise, send16Seen;

	assign nextState = ltssmPkg::ltssmStateE'(SetTXState);
	assign stateChange = nextState != state; // Main LTSSM has moved on
	assign entered = state != prevState;
	// Expiry left over from the last interval, masked until the reload lands
	assign timeOutQ = timeOut && !entered && !timerStart;
	assign send16Rise = startSend16 && !send16Q;

	always_comb begin
		exitFound = 1'b0;
		exitTo = state;
		case (state)
			ltssmPkg::DetectQuiet: begin
				exitFound = timeOutQ;
				exitTo = ltssmPkg::DetectActive;
			end
			ltssmPkg::DetectActive: begin
				if (allDetected || (timeOutQ && !noneDetected)) begin
					exitFound = 1'b1;
					exitTo = ltssmPkg::PollingActive;
				end else if (timeOutQ) begin
					exitFound = 1'b1;
					exitTo = ltssmPkg::DetectQuiet; // Nobody on the far end
				end
			end
			ltssmPkg::PollingActive: begin
				exitFound = osCount >= pollActiveOs;
				exitTo = ltssmPkg::PollingConfig;
			end
			ltssmPkg::PollingConfig: begin
				exitFound = osCount >= pollCfgOs;
				exitTo = ltssmPkg::ConfigLinkWidthStart;
			end
			ltssmPkg::ConfigLinkWidthAccept: begin
				exitFound = OSGeneratorFinish;
				exitTo = ltssmPkg::ConfigLaneNumWait;
			end
			ltssmPkg::ConfigComplete: begin
				exitFound = osCount >= cplOs;
				exitTo = ltssmPkg::ConfigIdle;
			end
			ltssmPkg::ConfigIdle: begin
				exitFound = send16Seen && (osCount - markCount >= idleOs);
				exitTo = ltssmPkg::L0;
			end
			default: ;
		endcase
	end

	assign exitGo = exitFound && !stateChange;
	assign captureLanes = exitGo && (state == ltssmPkg::DetectActive)
		&& (exitTo == ltssmPkg::PollingActive);

	always_ff @(posedge Pclk) begin
		if (!rstN) begin
			state <= ltssmPkg::Idle;
			prevState <= ltssmPkg::Idle;
			timerStart <= 1'b0;
			timerCode <= ltssmPkg::tNone;
			osCount <= '0;
			send16Q <= 1'b0;
			send16Seen <= 1'b0;
			TXFinishFlag <= 1'b0;
			TXExitTo <= ltssmPkg::DetectQuiet;
		end else begin
			state <= nextState;
			prevState <= state;
			timerStart <= entered && (state == ltssmPkg::DetectQuiet
				|| state == ltssmPkg::DetectActive);
			if (entered) begin
				timerCode <= ltssmPkg::t12ms; // Both Detect states use the same interval
			end
			osCount <= stateChange ? '0 : osCount + osW'(OSGeneratorFinish);
			send16Q <= startSend16;
			if (stateChange) begin
				send16Seen <= 1'b0;
			end else if (send16Rise) begin
				send16Seen <= 1'b1;
			end
			TXFinishFlag <= exitGo;
			if (exitGo) begin
				TXExitTo <= exitTo;
			end
		end
	end

	// Count snapshot at the startSend16 edge
	always_ff @(posedge Pclk) begin
		if (send16Rise) begin
			markCount <= osCount;
		end
	end

	// Main LTSSM only commands codes this block knows
	legalSetState: assert property (@(posedge Pclk) disable iff (!rstN)
		SetTXState inside {[ltssmPkg::DetectQuiet:ltssmPkg::L0], ltssmPkg::Idle})
		else $error("SetTXState carries an unknown state code");

endmodule

`default_nettype wire

//--- test/txLtssmTb.sv
`default_nettype none
`include "ltssm_macros.svh"

module txLtssmTb #(
	parameter bit isUpstream = 1'b0
);
	localparam int numRows = 12;
	localparam logic [7:0] readLink = 8'h05;
	localparam logic [1:0] waitFlag = 2'd0;
	localparam logic [1:0] waitStart = 2'd1;
	localparam logic [1:0] waitSettle = 2'd2;
	localparam logic [1:0] noFins = 2'd0;
	localparam logic [1:0] sinceEntry = 2'd1;
	localparam logic [1:0] sinceSend16 = 2'd2;
	// Four cycles per ordered set, plus four detect intervals and some slack
	localparam int cycleLimit = (`LTSSM_POLL_ACTIVE_OS + `LTSSM_POLL_CFG_OS + `LTSSM_CPL_OS_DSP
		+ `LTSSM_IDLE_AFTER_SEND16 + 8) * 4 + 4 * (`LTSSM_DETECT_CYCLES + 4) + 200;

	typedef struct packed {
		ltssmPkg::ltssmStateE setState;
		logic [`LTSSM_LANES-1:0] status;
		logic [7:0] readLink;
		logic [1:0] waitOn;
		ltssmPkg::ltssmStateE expExit;
		logic checkOs;
		ltssmPkg::osTypeE expOs;
		logic [7:0] expLink;
		logic [1:0] finMode;
		logic [15:0] expFins;
		logic checkLanes;
	} rowT;

	logic Pclk, rstN;
	logic [`LTSSM_STATE_W-1:0] SetTXState, TXExitTo;
	logic [`LTSSM_LANES-1:0] DetectStatus, DetectLanes, DetectReq, ElecIdleReq;
	logic [7:0] ReadLinkNum, WriteLinkNum, LinkNumber;
	logic [`LTSSM_LANE_COUNT_W-1:0] NumberDetectLanes;
	logic [2:0] OSType, Rate;
	logic [1:0] LaneNumber;
	logic TXFinishFlag, WriteLinkNumFlag, WriteDetectLanesFlag, Loopback, OSGeneratorStart;
	logic turnOffScrambler, HoldFIFOData, MuxSel;
	logic OSGeneratorBusy = 1'b0;
	logic OSGeneratorFinish = 1'b0;
	logic startSend16 = 1'b0;
	logic [1:0] busyLeft = '0;
	logic [2:0] idleDone = '0;
	logic busyLast = 1'b0;
	rowT rows [numRows];
	logic [`LTSSM_LANES-1:0] lanePattern;
	int errCount = 0;
	int passCount = 0;
	int failCount = 0;
	int cycleCount = 0;

	txLtssm #(.isUpstream(isUpstream)) DUT (.*);

	initial begin
		Pclk = 1'b0;
		forever #10 Pclk = ~Pclk;
	end

	// Generator model, busy two cycles per start then one finish
	always @(posedge Pclk) begin
		if (!rstN) begin
			busyLeft <= '0;
			OSGeneratorBusy <= 1'b0;
			OSGeneratorFinish <= 1'b0;
		end else begin
			OSGeneratorFinish <= 1'b0;
			if (busyLeft != '0) begin
				busyLeft <= busyLeft - 1'b1;
				if (busyLeft == 2'd1) begin
					OSGeneratorBusy <= 1'b0;
					OSGeneratorFinish <= 1'b1;
				end
			end else if (OSGeneratorStart) begin
				OSGeneratorBusy <= 1'b1;
				busyLeft <= 2'd2;
			end
		end
	end

	// startSend16 rises once the fourth IDLE is done
	always @(posedge Pclk) begin
		if (!rstN || SetTXState != ltssmPkg::ConfigIdle) begin
			idleDone <= '0;
			startSend16 <= 1'b0;
		end else if (OSGeneratorFinish && OSType == ltssmPkg::OsIdle) begin
			idleDone <= idleDone + 1'b1;
			if (idleDone == 3'd3) begin
				startSend16 <= 1'b1;
			end
		end
	end

	always @(negedge Pclk) begin
		if (rstN) begin
			assert (!(busyLast && OSGeneratorStart)) else begin
				errCount++;
				$display("[FAIL] %0t: OSGeneratorStart raised while generator busy", $time);
			end
		end
		busyLast = OSGeneratorBusy;
	end

	always @(posedge Pclk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout: no TXFinishFlag or ordered-set start within %0d cycles", cycleLimit);
			$display("Test FAILED");
			$finish;
		end
	end

	function automatic int laneCountOf(input logic [`LTSSM_LANES-1:0] lanes);
		for (int i = `LTSSM_LANES - 1; i >= 0; i--) begin
			if (lanes[i]) begin
				return i + 1;
			end
		end
		return 0;
	endfunction

	function automatic rowT makeRow(input ltssmPkg::ltssmStateE st,
		input logic [`LTSSM_LANES-1:0] status, input logic [7:0] link, input logic [1:0] waitOn,
		input ltssmPkg::ltssmStateE expExit, input logic checkOs, input ltssmPkg::osTypeE expOs,
		input logic [7:0] expLink, input logic [1:0] finMode, input logic [15:0] expFins);
		rowT r;
		r = '{st, status, link, waitOn, expExit, checkOs, expOs, expLink, finMode, expFins, 1'b0};
		return r;
	endfunction

	task automatic expectValue(input string what, input int got, input int exp);
		assert (got == exp) else begin
			errCount++;
			$display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic reportTest(input string name, input int errsBefore);
		if (errCount == errsBefore) begin
			passCount++;
			$display("%-24s passed", name);
		end else begin
			failCount++;
			$display("%-24s failed", name);
		end
	endtask

	task automatic runRow(input int idx);
		rowT r;
		ltssmPkg::ltssmStateE st;
		int finCount, send16Fins, waited, errsBefore;
		bit done;
		r = rows[idx];
		st = r.setState;
		errsBefore = errCount;
		@(posedge Pclk);
		SetTXState <= r.setState;
		DetectStatus <= r.status;
		ReadLinkNum <= r.readLink;
		@(posedge Pclk); // DUT has taken the new state
		finCount = 0;
		send16Fins = 0;
		waited = 0;
		done = 1'b0;
		while (!done) begin
			@(negedge Pclk);
			case (r.waitOn)
				waitFlag: done = TXFinishFlag;
				waitStart: done = OSGeneratorStart && waited > 0; // First start is stale
				default: done = waited >= 3;
			endcase
			if (!done && OSGeneratorFinish) begin
				finCount++;
				if (startSend16) begin
					send16Fins++;
				end
			end
			waited++;
		end
		if (r.waitOn == waitFlag) begin
			expectValue("TXExitTo", int'(TXExitTo), int'(r.expExit));
		end
		if (r.checkOs) begin
			expectValue("OSType", int'(OSType), int'(r.expOs));
			expectValue("LinkNumber", int'(LinkNumber), int'(r.expLink));
			expectValue("Rate", int'(Rate), 1); // Gen1 training
			expectValue("Loopback", int'(Loopback), 0);
		end
		if (r.finMode == sinceEntry) begin
			expectValue("finishes in state", finCount, int'(r.expFins));
		end else if (r.finMode == sinceSend16) begin
			expectValue("finishes after startSend16", send16Fins, int'(r.expFins));
		end
		if (r.checkLanes) begin
			expectValue("DetectLanes", int'(DetectLanes), int'(lanePattern));
			expectValue("NumberDetectLanes", int'(NumberDetectLanes), laneCountOf(lanePattern));
		end
		case (st)
			ltssmPkg::DetectQuiet: expectValue("ElecIdleReq", int'(ElecIdleReq), 16'hFFFF);
			ltssmPkg::DetectActive: begin
				expectValue("DetectReq", int'(DetectReq), 16'hFFFF);
				expectValue("WriteDetectLanesFlag", int'(WriteDetectLanesFlag),
					int'(r.status != '0));
			end
			ltssmPkg::PollingActive, ltssmPkg::PollingConfig: begin
				expectValue("LaneNumber", int'(LaneNumber), 0);
			end
			ltssmPkg::ConfigLinkWidthStart: begin
				expectValue("WriteLinkNumFlag", int'(WriteLinkNumFlag), int'(!isUpstream));
				if (!isUpstream) begin
					expectValue("WriteLinkNum", int'(WriteLinkNum), `LTSSM_DSP_LINK_NUM);
				end
			end
			ltssmPkg::ConfigIdle: expectValue("turnOffScrambler", int'(turnOffScrambler), 0);
			ltssmPkg::L0: begin
				expectValue("HoldFIFOData", int'(HoldFIFOData), 0);
				expectValue("MuxSel", int'(MuxSel), 1);
				expectValue("turnOffScrambler", int'(turnOffScrambler), 0);
			end
			default: ;
		endcase
		reportTest(st.name(), errsBefore);
	endtask

	initial begin
		int errsBefore;
		logic [15:0] cplFins;
		void'($urandom(32'h8406));
		rstN = 1'b0;
		SetTXState = ltssmPkg::Idle;
		DetectStatus = '0;
		ReadLinkNum = '0;
		do begin
			lanePattern = `LTSSM_LANES'($urandom);
		end while (lanePattern == '0 || &lanePattern); // Partial detect only
		cplFins = isUpstream ? 16'(`LTSSM_CPL_OS_USP) : 16'(`LTSSM_CPL_OS_DSP);

		rows[0] = makeRow(ltssmPkg::DetectQuiet, '0, '0, waitFlag,
			ltssmPkg::DetectActive, 1'b0, ltssmPkg::OsTs1, '0, noFins, '0);
		rows[1] = makeRow(ltssmPkg::DetectActive, '0, '0, waitFlag,
			ltssmPkg::DetectQuiet, 1'b0, ltssmPkg::OsTs1, '0, noFins, '0);
		rows[2] = makeRow(ltssmPkg::DetectQuiet, '0, '0, waitFlag,
			ltssmPkg::DetectActive, 1'b0, ltssmPkg::OsTs1, '0, noFins, '0);
		rows[3] = makeRow(ltssmPkg::DetectActive, lanePattern, '0, waitFlag,
			ltssmPkg::PollingActive, 1'b0, ltssmPkg::OsTs1, '0, noFins, '0);
		rows[4] = makeRow(ltssmPkg::PollingActive, lanePattern, '0, waitFlag,
			ltssmPkg::PollingConfig, 1'b1, ltssmPkg::OsTs1, '0, sinceEntry,
			16'(`LTSSM_POLL_ACTIVE_OS));
		rows[5] = makeRow(ltssmPkg::PollingConfig, lanePattern, '0, waitFlag,
			ltssmPkg::ConfigLinkWidthStart, 1'b1, ltssmPkg::OsTs2, '0, sinceEntry,
			16'(`LTSSM_POLL_CFG_OS));
		rows[6] = makeRow(ltssmPkg::ConfigLinkWidthStart, lanePattern, readLink, waitStart,
			ltssmPkg::Idle, 1'b1, ltssmPkg::OsTs1, isUpstream ? 8'd0 : 8'(`LTSSM_DSP_LINK_NUM),
			noFins, '0);
		rows[7] = makeRow(ltssmPkg::ConfigLinkWidthAccept, lanePattern, readLink, waitFlag,
			ltssmPkg::ConfigLaneNumWait, 1'b0, ltssmPkg::OsTs1, readLink, noFins, '0);
		rows[8] = makeRow(ltssmPkg::ConfigLaneNumWait, lanePattern, readLink, waitStart,
			ltssmPkg::Idle, 1'b1, ltssmPkg::OsTs1, readLink, noFins, '0);
		rows[9] = makeRow(ltssmPkg::ConfigComplete, lanePattern, readLink, waitFlag,
			ltssmPkg::ConfigIdle, 1'b1, ltssmPkg::OsTs2, readLink, sinceEntry, cplFins);
		rows[10] = makeRow(ltssmPkg::ConfigIdle, lanePattern, readLink, waitFlag,
			ltssmPkg::L0, 1'b1, ltssmPkg::OsIdle, readLink, sinceSend16,
			16'(`LTSSM_IDLE_AFTER_SEND16));
		rows[11] = makeRow(ltssmPkg::L0, lanePattern, readLink, waitSettle,
			ltssmPkg::Idle, 1'b0, ltssmPkg::OsTs1, readLink, noFins, '0);
		for (int i = 3; i < numRows; i++) begin
			rows[i].checkLanes = 1'b1; // Lanes stay captured from here on
		end

		repeat (3) @(posedge Pclk);
		rstN <= 1'b1;
		@(negedge Pclk);
		errsBefore = errCount;
		expectValue("TXFinishFlag", int'(TXFinishFlag), 0);
		expectValue("OSGeneratorStart", int'(OSGeneratorStart), 0);
		expectValue("HoldFIFOData", int'(HoldFIFOData), 1);
		expectValue("turnOffScrambler", int'(turnOffScrambler), 1);
		reportTest("Reset", errsBefore);

		for (int i = 0; i < numRows; i++) begin
			runRow(i);
		end

		$display("%0d tests, %0d passed, %0d failed, %0d errors",
			passCount + failCount, passCount, failCount, errCount);
		if (errCount == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- txLtssm.f
+incdir+include
rtl/ltssmPkg.sv
rtl/ltssmTimer.sv
rtl/laneDetect.sv
rtl/txStateTrack.sv
rtl/osRequest.sv
rtl/txLtssm.sv
test/txLtssmTb.sv
